// ==== tests/decode_golden.txt ====
# instr uop ifmt dst(reg type size) src1(reg type size) src2(reg type size) imm64
# enums as numbers, pc is line index times 4, last eight lines are filler
007302B3 0 0 5 1 1 6 1 1 7 1 1 0000000000000000
407302B3 1 0 5 1 1 6 1 1 7 1 1 0000000000000000
007312B3 2 0 5 1 1 6 1 1 7 1 1 0000000000000000
007322B3 3 0 5 1 1 6 1 1 7 1 1 0000000000000000
007332B3 4 0 5 1 1 6 1 1 7 1 1 0000000000000000
007342B3 5 0 5 1 1 6 1 1 7 1 1 0000000000000000
007352B3 6 0 5 1 1 6 1 1 7 1 1 0000000000000000
407352B3 7 0 5 1 1 6 1 1 7 1 1 0000000000000000
007362B3 8 0 5 1 1 6 1 1 7 1 1 0000000000000000
007372B3 9 0 5 1 1 6 1 1 7 1 1 0000000000000000
007302BB 0 0 5 1 0 6 1 0 7 1 0 0000000000000000
407302BB 1 0 5 1 0 6 1 0 7 1 0 0000000000000000
407352BB 7 0 5 1 0 6 1 0 7 1 0 0000000000000000
00558513 0 1 10 1 1 11 1 1 0 2 1 0000000000000005
FFF58513 0 1 10 1 1 11 1 1 0 2 1 FFFFFFFFFFFFFFFF
80058513 0 1 10 1 1 11 1 1 0 2 1 FFFFFFFFFFFFF800
7FF5A513 3 1 10 1 1 11 1 1 0 2 1 00000000000007FF
F005C513 5 1 10 1 1 11 1 1 0 2 1 FFFFFFFFFFFFFF00
00359513 2 1 10 1 1 11 1 1 0 2 1 0000000000000003
0045D513 6 1 10 1 1 11 1 1 0 2 1 0000000000000004
4045D513 7 1 10 1 1 11 1 1 0 2 1 0000000000000404
FFD5851B 0 1 10 1 0 11 1 0 0 2 0 FFFFFFFFFFFFFFFD
4025D51B 7 1 10 1 0 11 1 0 0 2 0 0000000000000402
00D60463 10 3 0 0 0 12 1 1 13 1 1 0000000000000008
FED61EE3 11 3 0 0 0 12 1 1 13 1 1 FFFFFFFFFFFFFFFC
00D640E3 12 3 0 0 0 12 1 1 13 1 1 0000000000000800
80D65063 13 3 0 0 0 12 1 1 13 1 1 FFFFFFFFFFFFF000
06D66F63 14 3 0 0 0 12 1 1 13 1 1 000000000000007E
00D67863 15 3 0 0 0 12 1 1 13 1 1 0000000000000010
00013083 16 1 0 0 0 0 0 0 0 0 0 0000000000000000
00113423 16 2 0 0 0 0 0 0 0 0 0 0000000000000000
008000EF 16 5 0 0 0 0 0 0 0 0 0 0000000000000000
123452B7 16 4 0 0 0 0 0 0 0 0 0 0000000000000000
007302B3 0 0 5 1 1 6 1 1 7 1 1 0000000000000000
FFF58513 0 1 10 1 1 11 1 1 0 2 1 FFFFFFFFFFFFFFFF
00D60463 10 3 0 0 0 12 1 1 13 1 1 0000000000000008
123452B7 16 4 0 0 0 0 0 0 0 0 0 0000000000000000
407302B3 1 0 5 1 1 6 1 1 7 1 1 0000000000000000
4045D513 7 1 10 1 1 11 1 1 0 2 1 0000000000000404
80D65063 13 3 0 0 0 12 1 1 13 1 1 FFFFFFFFFFFFF000
00013083 16 1 0 0 0 0 0 0 0 0 0 0000000000000000

// ==== project.f ====
verilog/rv_decode_pkg.sv
verilog/fetch_queue.sv
verilog/decode.sv
verilog/decode_frontend.sv
tests/decode_frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module decode_frontend_tb \
    -o decode_frontend_sim > build.log 2>&1 \
    || { cat build.log; echo "Checks failed" > sim.log; }
[ -f sim.log ] || ./obj_dir/decode_frontend_sim > sim.log 2>&1 \
    || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== tests/decode_frontend_tb.sv ====
`timescale 1ns/1ps

module decode_frontend_tb
    import rv_decode_pkg::*;
();

localparam int max_lines = 64;

logic       clk;
logic       reset = 1'b1;
logic       req = 1'b0;
t_instr_pkt pkt = '0;
logic       stall = 1'b0;
logic       br_mispred = 1'b0;
logic       ack;
logic       valid_de1;
t_uinstr    uinstr_de1;

// golden table
logic [31:0] g_instr [max_lines];
int          g_uop [max_lines];
int          g_fmt [max_lines];
logic [7:0]  g_dst [max_lines];
logic [7:0]  g_src1 [max_lines];
logic [7:0]  g_src2 [max_lines];
logic [63:0] g_imm [max_lines];
int          n_lines = 0;
int          limit = 1000;
int          src_idx = 0;
int          run_errors = 0;

// owned by the per-cycle monitor
int   seed = 89705;
int   exp_q [$];
int   check_errors = 0;
int   checks = 0;
int   retired = 0;
int   dropped = 0;
int   after_mispred = 0;
int   cycles = 0;
int   burst_left = 0;
int   wait_run = 0;
logic burst_done = 1'b0;
logic mispred_done = 1'b0;
logic mispred_prev = 1'b0;
logic prev_ack = 1'b0;
logic pressure_seen = 1'b0;

decode_frontend dut0 (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .pkt        (pkt),
    .ack        (ack),
    .stall      (stall),
    .br_mispred (br_mispred),
    .valid_de1  (valid_de1),
    .uinstr_de1 (uinstr_de1)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

task automatic read_golden();
    int          fd;
    int          n;
    int          u, fm, dr, dt, ds, ar, at, as, br, bt, bs;
    logic [31:0] w;
    logic [63:0] imm;
    string       line;
    fd = $fopen("tests/decode_golden.txt", "r");
    if (fd == 0) begin
        $display("cannot open tests/decode_golden.txt");
        run_errors++;
        return;
    end
    while (!$feof(fd) && n_lines < max_lines) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%h %d %d %d %d %d %d %d %d %d %d %d %h",
                        w, u, fm, dr, dt, ds, ar, at, as, br, bt, bs, imm);
            if (n == 13) begin
                g_instr[n_lines] = w;
                g_uop[n_lines]   = u;
                g_fmt[n_lines]   = fm;
                g_dst[n_lines]   = {dr[4:0], dt[1:0], ds[0]};
                g_src1[n_lines]  = {ar[4:0], at[1:0], as[0]};
                g_src2[n_lines]  = {br[4:0], bt[1:0], bs[0]};
                g_imm[n_lines]   = imm;
                n_lines++;
            end else begin
                $display("malformed golden line: %s", line);
                run_errors++;
            end
        end
    end
    $fclose(fd);
endtask

// four-phase source, one packet per call
task automatic send_packet(input int idx);
    while (ack) @(negedge clk);
    src_idx   = idx;
    pkt.pc    = 64'(idx * 4);
    pkt.instr = g_instr[idx];
    req       = 1'b1;
    @(negedge clk);
    while (!ack) @(negedge clk);
    req = 1'b0;
endtask

task automatic check_field(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp == act) else begin
        $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
        check_errors++;
    end
endtask

task automatic retire_check();
    int         i;
    logic [2:0] f3;
    logic [6:0] f7;
    checks++;
    assert (exp_q.size() != 0) else begin
        $display("valid_de1 at %0t with no packet outstanding", $time);
        check_errors++;
    end
    if (exp_q.size() != 0) begin
        i = exp_q.pop_front();
        // only decoded formats keep their funct fields
        f3 = (g_uop[i] != int'(UOP_ILLEGAL)) ? g_instr[i][14:12] : 3'b000;
        f7 = (g_fmt[i] == int'(RV_FMT_R)) ? g_instr[i][31:25] : 7'b0000000;
        check_field("valid", 64'(1), 64'(uinstr_de1.valid));
        check_field("pc", 64'(i * 4), uinstr_de1.pc);
        check_field("opcode", 64'(g_instr[i][6:0]), 64'(uinstr_de1.opcode));
        check_field("uop", 64'(g_uop[i]), 64'(uinstr_de1.uop));
        check_field("ifmt", 64'(g_fmt[i]), 64'(uinstr_de1.ifmt));
        check_field("funct3", 64'(f3), 64'(uinstr_de1.funct3));
        check_field("funct7", 64'(f7), 64'(uinstr_de1.funct7));
        check_field("dst", 64'(g_dst[i]), 64'(uinstr_de1.dst));
        check_field("src1", 64'(g_src1[i]), 64'(uinstr_de1.src1));
        check_field("src2", 64'(g_src2[i]), 64'(uinstr_de1.src2));
        check_field("imm64", g_imm[i], uinstr_de1.imm64);
        retired++;
        if (mispred_done) begin
            after_mispred++;
        end
    end
endtask

// drive stall and mispredict on the falling edge, then sample
always @(negedge clk) begin
    if (!reset) begin
        cycles++;
        if (!burst_done && src_idx >= 12) begin
            burst_left = 16;
            burst_done = 1'b1;
        end
        if (burst_left > 0) begin
            stall = 1'b1;
            burst_left--;
        end else begin
            stall = ($unsigned($random(seed)) % 100) < 30;
        end
        // fire once the head is one of the trailing filler lines
        br_mispred = 1'b0;
        if (!mispred_done && exp_q.size() != 0 && exp_q[0] >= n_lines - 8) begin
            br_mispred   = 1'b1;
            mispred_done = 1'b1;
        end
        #1;
        if (ack && !prev_ack) begin
            if (mispred_prev) begin
                dropped++;
            end else begin
                exp_q.push_back(src_idx);
            end
        end
        if (mispred_prev) begin
            dropped += exp_q.size();
            exp_q.delete();
        end
        if (br_mispred) begin
            checks++;
            assert (!valid_de1) else begin
                $display("valid_de1 high during mispredict at %0t", $time);
                check_errors++;
            end
        end
        if (valid_de1 && !stall) begin
            retire_check();
        end
        wait_run = (req && !ack) ? wait_run + 1 : 0;
        if (wait_run >= 4) begin
            pressure_seen = 1'b1;
        end
        prev_ack     = ack;
        mispred_prev = br_mispred;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, %0d packets outstanding", cycles, exp_q.size());
            $display("Checks failed");
            $finish;
        end
    end
end

initial begin
    read_golden();
    limit = n_lines * 20 + 200;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int k = 0; k < n_lines; k++) begin
        send_packet(k);
    end
    while (exp_q.size() != 0 || ack) @(negedge clk);
    repeat (4) @(negedge clk);

    assert (n_lines > 0) else begin
        $display("no golden lines were read");
        run_errors++;
    end
    assert (retired + dropped == n_lines) else begin
        $display("packets lost or duplicated: %0d retired, %0d dropped, %0d sent",
                 retired, dropped, n_lines);
        run_errors++;
    end
    assert (pressure_seen) else begin
        $display("queue never pushed back on the source");
        run_errors++;
    end
    assert (mispred_done) else begin
        $display("mispredict was never issued");
        run_errors++;
    end
    assert (after_mispred > 0) else begin
        $display("nothing decoded after the mispredict");
        run_errors++;
    end

    $display("errors %0d (checks %0d of %0d, run %0d), retired %0d, dropped %0d",
             check_errors + run_errors, check_errors, checks, run_errors, retired, dropped);
    if (check_errors + run_errors == 0) begin
        $display("All checks passed");
    end else begin
        $display("Checks failed");
    end
    $finish;
end

endmodule

// ==== verilog/decode_frontend.sv ====
`timescale 1ns/1ps

module decode_frontend
    import rv_decode_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // instruction source, four-phase handshake
    input  logic       req,
    input  t_instr_pkt pkt,
    output logic       ack,

    // pipeline control
    input  logic       stall,
    input  logic       br_mispred,

    output logic       valid_de1,
    output t_uinstr    uinstr_de1
);

logic       valid_fe1;
t_instr_pkt instr_fe1;

fetch_queue fq0 (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .pkt       (pkt),
    .ack       (ack),
    .stall     (stall),
    // mispredict empties the queue
    .flush     (br_mispred),
    .valid_fe1 (valid_fe1),
    .instr_fe1 (instr_fe1)
);

decode de0 (
    .clk        (clk),
    .reset      (reset),
    .valid_fe1  (valid_fe1),
    .instr_fe1  (instr_fe1),
    .stall      (stall),
    .br_mispred (br_mispred),
    .valid_de1  (valid_de1),
    .uinstr_de1 (uinstr_de1)
);

endmodule

// ==== verilog/decode.sv ====
`timescale 1ns/1ps

module decode
    import rv_decode_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       valid_fe1,
    input  t_instr_pkt instr_fe1,
    input  logic       stall,
    input  logic       br_mispred,
    output logic       valid_de1,
    output t_uinstr    uinstr_de1
);

logic [31:0] instr;
t_rv_opcode  opcode_de0;
t_rv_fmt     ifmt_de0;
t_opsize     sz_de0;
logic        alu_imm_de0;
logic [4:0]  rd;
logic [4:0]  rs1;
logic [4:0]  rs2;
logic [2:0]  funct3;
logic [6:0]  funct7;
logic [11:0] imm_i;
logic [12:0] imm_b;
t_uinstr     uinstr_de0;

logic        valid_q;
t_uinstr     uinstr_q;

// raw instruction fields
always_comb instr  = instr_fe1.instr;
always_comb rd     = instr[11:7];
always_comb funct3 = instr[14:12];
always_comb rs1    = instr[19:15];
always_comb rs2    = instr[24:20];
always_comb funct7 = instr[31:25];
always_comb imm_i  = instr[31:20];
always_comb imm_b  = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

// DE0
always_comb opcode_de0  = t_rv_opcode'(instr[6:0]);
always_comb ifmt_de0    = get_instr_format(opcode_de0);
// W-suffix opcodes have bit 3 set
always_comb sz_de0      = opcode_de0[3] ? SZ_4B : SZ_8B;
always_comb alu_imm_de0 = (opcode_de0 == RV_OP_IMM) || (opcode_de0 == RV_OP_IMM_32);

always_comb begin
    uinstr_de0        = '0;
    uinstr_de0.valid  = valid_fe1;
    uinstr_de0.pc     = instr_fe1.pc;
    uinstr_de0.opcode = opcode_de0;
    uinstr_de0.ifmt   = ifmt_de0;
    uinstr_de0.uop    = rv_instr_to_uop(instr);

    case (ifmt_de0)
        RV_FMT_R: begin
            uinstr_de0.funct7 = funct7;
            uinstr_de0.funct3 = funct3;
            uinstr_de0.dst    = '{opreg: rd,  optype: OP_REG, opsize: sz_de0};
            uinstr_de0.src1   = '{opreg: rs1, optype: OP_REG, opsize: sz_de0};
            uinstr_de0.src2   = '{opreg: rs2, optype: OP_REG, opsize: sz_de0};
        end
        RV_FMT_I: begin
            // loads, jalr and system stay illegal
            if (alu_imm_de0) begin
                uinstr_de0.funct3 = funct3;
                uinstr_de0.dst    = '{opreg: rd,  optype: OP_REG, opsize: sz_de0};
                uinstr_de0.src1   = '{opreg: rs1, optype: OP_REG, opsize: sz_de0};
                uinstr_de0.src2   = '{opreg: '0,  optype: OP_IMM, opsize: sz_de0};
                uinstr_de0.imm64  = sext12(imm_i);
            end
        end
        RV_FMT_B: begin
            uinstr_de0.funct3 = funct3;
            uinstr_de0.src1   = '{opreg: rs1, optype: OP_REG, opsize: SZ_8B};
            uinstr_de0.src2   = '{opreg: rs2, optype: OP_REG, opsize: SZ_8B};
            uinstr_de0.imm64  = sext13(imm_b);
        end
        default: begin
            // S, U, J and unknown formats keep only the header fields
        end
    endcase
end

// DE1
always_ff @(posedge clk) begin
    if (reset || br_mispred) begin
        valid_q <= 1'b0;
    end else if (!stall) begin
        valid_q <= valid_fe1;
    end
end

always_ff @(posedge clk) begin
    if (!stall) begin
        uinstr_q <= uinstr_de0;
    end
end

// mispredict kills DE1 in the same cycle
always_comb valid_de1 = valid_q && !br_mispred;

always_comb begin
    uinstr_de1       = uinstr_q;
    uinstr_de1.valid = valid_de1;
end

a_hold_on_stall: assert property (
    @(posedge clk) disable iff (reset)
    (stall && valid_de1) |=> ($stable(uinstr_de1) || br_mispred)
) else $error("decode DE1 changed while stalled");

endmodule

// ==== verilog/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue
    import rv_decode_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    input  t_instr_pkt pkt,
    output logic       ack,
    input  logic       stall,
    input  logic       flush,
    output logic       valid_fe1,
    output t_instr_pkt instr_fe1
);

typedef enum logic {
    ACK_IDLE,
    ACK_HIGH
} t_ack_state;

t_ack_state          ack_state;
t_instr_pkt          entries [fq_depth];
logic [fq_ptr_w-1:0] rd_ptr;
logic [fq_ptr_w-1:0] wr_ptr;
logic [fq_cnt_w-1:0] count;
logic                full;
logic                store;
logic                push;
logic                pop;

function automatic logic [fq_ptr_w-1:0] ptr_inc(input logic [fq_ptr_w-1:0] ptr);
    return (ptr == fq_ptr_w'(fq_depth - 1)) ? '0 : ptr + 1'b1;
endfunction

always_comb full  = (count == fq_cnt_w'(fq_depth));
// store edge is the edge that raises ack
always_comb store = (ack_state == ACK_IDLE) && req && !full;
// handshake still completes on flush, packet is lost
always_comb push  = store && !flush;
always_comb pop   = valid_fe1 && !stall;

always_comb ack       = (ack_state == ACK_HIGH);
always_comb valid_fe1 = (count != '0);
always_comb instr_fe1 = entries[rd_ptr];

always_ff @(posedge clk) begin
    if (reset) begin
        ack_state <= ACK_IDLE;
    end else begin
        case (ack_state)
            ACK_IDLE: if (store) ack_state <= ACK_HIGH;
            ACK_HIGH: if (!req) ack_state <= ACK_IDLE;
            default:  ack_state <= ACK_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (reset || flush) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
        end
        if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
        end
        count <= count + fq_cnt_w'(push) - fq_cnt_w'(pop);
    end
end

always_ff @(posedge clk) begin
    if (push) begin
        entries[wr_ptr] <= pkt;
    end
end

// a store into a full queue would push the count past the depth
a_no_store_full: assert property (
    @(posedge clk) disable iff (reset)
    count <= fq_cnt_w'(fq_depth)
) else $error("fetch_queue stored into a full queue");

a_ack_needs_req: assert property (
    @(posedge clk) disable iff (reset)
    ack |-> $past(req)
) else $error("fetch_queue ack high without prior req");

endmodule

// ==== verilog/rv_decode_pkg.sv ====
package rv_decode_pkg;

// fetch queue geometry
localparam int fq_depth = 4;
localparam int fq_ptr_w = $clog2(fq_depth);
localparam int fq_cnt_w = $clog2(fq_depth + 1);

// major opcodes, bits [6:0] of the instruction word
typedef enum logic [6:0] {
    RV_OP        = 7'b0110011,
    RV_OP_32     = 7'b0111011,
    RV_OP_IMM    = 7'b0010011,
    RV_OP_IMM_32 = 7'b0011011,
    RV_BRANCH    = 7'b1100011,
    RV_LOAD      = 7'b0000011,
    RV_STORE     = 7'b0100011,
    RV_JAL       = 7'b1101111,
    RV_JALR      = 7'b1100111,
    RV_LUI       = 7'b0110111,
    RV_AUIPC     = 7'b0010111,
    RV_SYSTEM    = 7'b1110011
} t_rv_opcode;

typedef enum logic [2:0] {
    RV_FMT_R,
    RV_FMT_I,
    RV_FMT_S,
    RV_FMT_B,
    RV_FMT_U,
    RV_FMT_J,
    RV_FMT_X
} t_rv_fmt;

typedef enum logic [1:0] {
    OP_INVD,
    OP_REG,
    OP_IMM
} t_optype;

typedef enum logic {
    SZ_4B,
    SZ_8B
} t_opsize;

typedef enum logic [4:0] {
    UOP_ADD, UOP_SUB, UOP_SLL, UOP_SLT, UOP_SLTU,
    UOP_XOR, UOP_SRL, UOP_SRA, UOP_OR, UOP_AND,
    UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
    UOP_ILLEGAL
} t_uop;

typedef struct packed {
    logic [4:0] opreg;
    t_optype    optype;
    t_opsize    opsize;
} t_operand;

typedef struct packed {
    logic [63:0] pc;
    logic [31:0] instr;
} t_instr_pkt;

typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    t_rv_opcode  opcode;
    t_rv_fmt     ifmt;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    t_operand    dst;
    t_operand    src1;
    t_operand    src2;
    logic [63:0] imm64;
    t_uop        uop;
} t_uinstr;

function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
endfunction

function automatic logic [63:0] sext13(input logic [12:0] v);
    return {{51{v[12]}}, v};
endfunction

function automatic t_rv_fmt get_instr_format(input t_rv_opcode opcode);
    t_rv_fmt fmt;
    case (opcode)
        RV_OP, RV_OP_32:                                   fmt = RV_FMT_R;
        RV_OP_IMM, RV_OP_IMM_32, RV_LOAD, RV_JALR, RV_SYSTEM: fmt = RV_FMT_I;
        RV_STORE:                                          fmt = RV_FMT_S;
        RV_BRANCH:                                         fmt = RV_FMT_B;
        RV_LUI, RV_AUIPC:                                  fmt = RV_FMT_U;
        RV_JAL:                                            fmt = RV_FMT_J;
        default:                                           fmt = RV_FMT_X;
    endcase
    return fmt;
endfunction

// shared by register and immediate ALU forms
function automatic t_uop rv_alu_uop(input logic [2:0] funct3, input logic f7b5);
    t_uop uop;
    case (funct3)
        3'b000:  uop = f7b5 ? UOP_SUB : UOP_ADD;
        3'b001:  uop = UOP_SLL;
        3'b010:  uop = UOP_SLT;
        3'b011:  uop = UOP_SLTU;
        3'b100:  uop = UOP_XOR;
        3'b101:  uop = f7b5 ? UOP_SRA : UOP_SRL;
        3'b110:  uop = UOP_OR;
        default: uop = UOP_AND;
    endcase
    return uop;
endfunction

function automatic t_uop rv_instr_to_uop(input logic [31:0] instr);
    t_rv_opcode opcode;
    logic [2:0] funct3;
    logic       f7b5;
    t_uop       uop;
    opcode = t_rv_opcode'(instr[6:0]);
    funct3 = instr[14:12];
    f7b5   = instr[30];
    case (opcode)
        RV_OP, RV_OP_32:         uop = rv_alu_uop(funct3, f7b5);
        // addi has no sub form, bit 30 is just immediate there
        RV_OP_IMM, RV_OP_IMM_32: uop = rv_alu_uop(funct3, f7b5 && (funct3 == 3'b101));
        RV_BRANCH: begin
            case (funct3)
                3'b000:  uop = UOP_BEQ;
                3'b001:  uop = UOP_BNE;
                3'b100:  uop = UOP_BLT;
                3'b101:  uop = UOP_BGE;
                3'b110:  uop = UOP_BLTU;
                3'b111:  uop = UOP_BGEU;
                default: uop = UOP_ILLEGAL;
            endcase
        end
        default: uop = UOP_ILLEGAL;
    endcase
    return uop;
endfunction

endpackage
